// File: hw/pce_input_config.svh
/* Controller port configuration */

`ifndef PCE_INPUT_CONFIG_SVH
`define PCE_INPUT_CONFIG_SVH

//////////////////////////////////////////////////
// Multitap
//////////////////////////////////////////////////

// Tap ports that carry a gamepad
`define PCE_NUM_PADS 5

//////////////////////////////////////////////////
// Mouse
//////////////////////////////////////////////////

// Clear-low cycles before the nibble phase resyncs
`define PCE_MOUSE_IDLE_CYCLES 32767

//////////////////////////////////////////////////
// Pachinko spring range
//////////////////////////////////////////////////

`define PCE_PACHINKO_MIN 3
`define PCE_PACHINKO_MAX 116
`define PCE_PACHINKO_HI_LIMIT 252
`define PCE_PACHINKO_LO_LIMIT 139

`endif

// File: hw/pce_input_pkg.sv
/* Controller port types */

package pce_input_pkg;

	//////////////////////////////////////////////////
	// Plain vectors
	//////////////////////////////////////////////////

	// Active-high buttons
	// 0 right, 1 left, 2 down, 3 up, 4 I, 5 II, 6 select, 7 run, 8..11 III..VI
	typedef logic [11:0] pad_buttons_t;

	// Four active-low nibbles of one port
	typedef logic [15:0] port_word_t;

	// Nibble returned to the console
	typedef logic [3:0] port_nibble_t;

	// Tap port number
	typedef logic [2:0] port_index_t;

	typedef logic [7:0] mouse_byte_t;

	// Raw analog stick axis
	typedef logic [7:0] stick_axis_t;

	//////////////////////////////////////////////////
	// Grouped signals
	//////////////////////////////////////////////////

	// Console side port lines
	typedef struct packed {
		logic clr;
		logic sel;
	} port_ctrl_t;

	// One motion report, valid for a single cycle
	typedef struct packed {
		logic        valid;
		mouse_byte_t dx;
		mouse_byte_t dy;
		logic        left;
		logic        right;
	} mouse_report_t;

	// Static option bits
	typedef struct packed {
		logic tap_en;
		logic six_button_en;
		logic mouse_en;
		logic pachinko_en;
	} input_cfg_t;

	// Which motion nibble the mouse sends next
	typedef enum logic [1:0] {
		MOUSE_X_HI,
		MOUSE_X_LO,
		MOUSE_Y_HI,
		MOUSE_Y_LO
	} mouse_phase_t;

endpackage

// File: hw/port_scanner.sv
/* Port line scanner */

module port_scanner
	import pce_input_pkg::*;
(
	input  logic         clk_sys,
	input  logic         reset,

	input  port_ctrl_t   port_ctrl,
	input  input_cfg_t   cfg,
	input  port_word_t   port_word,

	output port_nibble_t joy_in,
	output port_index_t  port_index,
	output logic         bank_high,
	output logic         clr_rise
);

	// Port lines from the previous cycle
	port_ctrl_t ctrl_prev;

	logic clr_edge;
	logic sel_edge;
	logic scan_en;

	assign clr_edge = port_ctrl.clr & ~ctrl_prev.clr;
	assign sel_edge = port_ctrl.sel & ~ctrl_prev.sel;

	// Pachinko sits on port 1, so it needs the scan too
	assign scan_en = cfg.tap_en | cfg.pachinko_en;

	//////////////////////////////////////////////////
	// Edge tracking and scan position
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ctrl_prev  <= '0;
			clr_rise   <= 1'b0;
			port_index <= '0;
			bank_high  <= 1'b0;
		end else begin
			ctrl_prev <= port_ctrl;
			clr_rise  <= clr_edge;

			if (port_ctrl.clr) begin
				port_index <= '0;
				// Six-button pads flip banks on every other clear
				if (clr_edge)
					bank_high <= ~bank_high & cfg.six_button_en;
			end else if (sel_edge && scan_en) begin
				port_index <= port_index + 3'd1;
			end
		end
	end

	//////////////////////////////////////////////////
	// Nibble latch
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			joy_in <= '0;
		end else if (port_ctrl.clr) begin
			joy_in <= '0;
		end else begin
			// Bank picks the upper pair, sel picks within the pair
			joy_in <= port_word[{bank_high, port_ctrl.sel, 2'b00} +: 4];
		end
	end

endmodule

// File: hw/mouse_tracker.sv
/* Mouse nibble sequencer */

`include "pce_input_config.svh"

module mouse_tracker
	import pce_input_pkg::*;
(
	input  logic          clk_sys,
	input  logic          reset,

	input  mouse_report_t mouse,
	input  logic          clr,
	input  logic          clr_rise,

	output mouse_byte_t   mouse_byte
);

	localparam int IDLE_W = $clog2(`PCE_MOUSE_IDLE_CYCLES + 1);
	localparam logic [IDLE_W-1:0] IDLE_LAST = IDLE_W'(`PCE_MOUSE_IDLE_CYCLES);

	mouse_phase_t      phase;
	logic [IDLE_W-1:0] idle_cnt;

	// Latest report, X already negated for the console
	mouse_byte_t cap_x;
	mouse_byte_t cap_y;
	logic        cap_left;
	logic        cap_right;

	// Motion frozen for one four-nibble read
	mouse_byte_t snap_x;
	mouse_byte_t snap_y;

	logic [3:0]  motion_nibble;

	//////////////////////////////////////////////////
	// Idle timeout and phase
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			idle_cnt <= '0;
			phase    <= MOUSE_Y_LO;
		end else begin
			if (clr)
				idle_cnt <= '0;
			else if (idle_cnt != IDLE_LAST)
				idle_cnt <= idle_cnt + 1'b1;

			// Long silence means the game restarts the sequence
			if (idle_cnt == IDLE_LAST)
				phase <= MOUSE_Y_LO;
			if (clr_rise)
				phase <= mouse_phase_t'(phase + 2'd1);
		end
	end

	//////////////////////////////////////////////////
	// Report capture and snapshot
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cap_x     <= '0;
			cap_y     <= '0;
			cap_left  <= 1'b0;
			cap_right <= 1'b0;
			snap_x    <= '0;
			snap_y    <= '0;
		end else begin
			if (clr_rise && phase == MOUSE_Y_LO) begin
				snap_x <= cap_x;
				snap_y <= cap_y;
				cap_x  <= '0;
				cap_y  <= '0;
			end
			// A fresh report replaces whatever was pending
			if (mouse.valid) begin
				cap_x     <= 8'd0 - mouse.dx;
				cap_y     <= mouse.dy;
				cap_left  <= mouse.left;
				cap_right <= mouse.right;
			end
		end
	end

	always_comb begin
		unique case (phase)
			MOUSE_X_HI: motion_nibble = snap_x[7:4];
			MOUSE_X_LO: motion_nibble = snap_x[3:0];
			MOUSE_Y_HI: motion_nibble = snap_y[7:4];
			MOUSE_Y_LO: motion_nibble = snap_y[3:0];
		endcase
	end

	// Run and select bits left released, the word builder fills them in
	assign mouse_byte = {motion_nibble, 2'b11, ~cap_left, ~cap_right};

endmodule

// File: hw/port_word_select.sv
/* Port word builder */

`include "pce_input_config.svh"

module port_word_select
	import pce_input_pkg::*;
(
	input  logic                              clk_sys,
	input  logic                              reset,

	input  pad_buttons_t [`PCE_NUM_PADS-1:0]  pads,
	input  mouse_byte_t                       mouse_byte,
	input  stick_axis_t                       stick_y,
	input  input_cfg_t                        cfg,
	input  port_index_t                       port_index,

	output port_word_t                        port_word
);

	localparam port_word_t NO_PAD_WORD = 16'h0FFF;

	localparam stick_axis_t PACH_HI_LIMIT = stick_axis_t'(`PCE_PACHINKO_HI_LIMIT);
	localparam stick_axis_t PACH_LO_LIMIT = stick_axis_t'(`PCE_PACHINKO_LO_LIMIT);
	localparam logic [6:0]  PACH_MIN      = 7'(`PCE_PACHINKO_MIN);
	localparam logic [6:0]  PACH_MAX      = 7'(`PCE_PACHINKO_MAX);

	logic [6:0]  pachinko;
	mouse_byte_t mouse_full;

	// Nibble 0 buttons, nibble 1 directions, nibble 2 III..VI, nibble 3 zero
	function automatic port_word_t pad_word(input pad_buttons_t b);
		port_word_t w;
		w = ~{4'hF, b[11:8], b[1], b[2], b[0], b[3], b[7:4]};
		return w;
	endfunction

	//////////////////////////////////////////////////
	// Pachinko position
	//////////////////////////////////////////////////

	// Only the upper half of the stick travel drives the spring
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			pachinko <= PACH_MIN;
		end else if (stick_y > PACH_HI_LIMIT || !stick_y[7]) begin
			pachinko <= PACH_MIN;
		end else if (stick_y < PACH_LO_LIMIT) begin
			pachinko <= PACH_MAX;
		end else begin
			pachinko <= 7'd0 - stick_y[6:0];
		end
	end

	//////////////////////////////////////////////////
	// Word select
	//////////////////////////////////////////////////

	// Pad-0 run and select share the mouse low nibble
	assign mouse_full = mouse_byte & {4'hF, ~pads[0][7], ~pads[0][6], 2'b11};

	always_comb begin
		if (port_index < `PCE_NUM_PADS)
			port_word = pad_word(pads[port_index]);
		else
			port_word = NO_PAD_WORD;

		// Special devices take over their own port
		if (port_index == 3'd0 && cfg.mouse_en)
			port_word = {mouse_full, mouse_full};
		else if (port_index == 3'd1 && cfg.pachinko_en)
			port_word = {9'd0, pachinko};
	end

endmodule

// File: hw/pce_input_top.sv
/* Controller port front end */

`include "pce_input_config.svh"

module pce_input_top
	import pce_input_pkg::*;
(
	input  logic                              clk_sys,
	input  logic                              reset,

	input  pad_buttons_t [`PCE_NUM_PADS-1:0]  pads,
	input  mouse_report_t                     mouse,
	input  stick_axis_t                       stick_y,
	input  input_cfg_t                        cfg,
	input  port_ctrl_t                        port_ctrl,

	output port_nibble_t                      joy_in
);

	port_index_t port_index;
	logic        clr_rise;
	mouse_byte_t mouse_byte;
	port_word_t  port_word;

	//////////////////////////////////////////////////
	// Scan and nibble latch
	//////////////////////////////////////////////////

	port_scanner port_scanner_inst (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.port_ctrl  (port_ctrl),
		.cfg        (cfg),
		.port_word  (port_word),
		.joy_in     (joy_in),
		.port_index (port_index),
		.bank_high  (),
		.clr_rise   (clr_rise)
	);

	//////////////////////////////////////////////////
	// Mouse on port 0
	//////////////////////////////////////////////////

	mouse_tracker mouse_tracker_inst (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.mouse      (mouse),
		.clr        (port_ctrl.clr),
		.clr_rise   (clr_rise),
		.mouse_byte (mouse_byte)
	);

	//////////////////////////////////////////////////
	// Per-port data
	//////////////////////////////////////////////////

	port_word_select port_word_select_inst (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.pads       (pads),
		.mouse_byte (mouse_byte),
		.stick_y    (stick_y),
		.cfg        (cfg),
		.port_index (port_index),
		.port_word  (port_word)
	);

endmodule

// File: tb/tb_pce_input.sv
/* Controller port testbench */

`include "pce_input_config.svh"

module tb_pce_input
	import pce_input_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int NUM_PADS = `PCE_NUM_PADS;
	localparam int SETTLE = 4;
	localparam int PAD_ROUNDS = 16;
	localparam int TAP_ROUNDS = 4;
	localparam int SCAN_PULSES = 6;
	localparam int SIX_ROUNDS = 6;
	localparam int MOUSE_ROUNDS = 3;
	localparam int MOUSE_PULSES = 8;
	localparam int PACH_RANDOM = 40;
	localparam int NUM_EDGES = 11;

	// Rough step count over all tests
	// A step is one drive plus the settle time
	localparam int NUM_STEPS = 4 + PAD_ROUNDS * 5 + TAP_ROUNDS * (2 + SCAN_PULSES * 2) + 12
		+ 2 * SIX_ROUNDS * 4 + MOUSE_ROUNDS * (1 + MOUSE_PULSES * 4) + 24
		+ (NUM_EDGES + PACH_RANDOM) * 4;
	localparam int WATCHDOG_CYCLES = 10 + 2 * NUM_STEPS * (SETTLE + 1)
		+ `PCE_MOUSE_IDLE_CYCLES + 500;

	// Stick values around the spring limits
	localparam stick_axis_t STICK_EDGES [NUM_EDGES] = '{
		8'd0, 8'd127, 8'd128, 8'd138, 8'd139, 8'd140, 8'd200, 8'd251, 8'd252, 8'd253, 8'd255
	};

	logic                        clk_sys;
	logic                        reset;
	pad_buttons_t [NUM_PADS-1:0] pads;
	mouse_report_t               mouse;
	stick_axis_t                 stick_y;
	input_cfg_t                  cfg;
	port_ctrl_t                  port_ctrl;
	port_nibble_t                joy_in;

	// Model of the port state
	port_index_t  m_index;
	logic         m_bank;
	mouse_phase_t m_phase;
	mouse_byte_t  m_cap_x;
	mouse_byte_t  m_cap_y;
	logic         m_left;
	logic         m_right;
	mouse_byte_t  m_snap_x;
	mouse_byte_t  m_snap_y;
	int           m_idle;

	// Stimulus to compare handshake
	int   req_cnt;
	int   ack_cnt;
	logic want_index;

	pce_input_top pce_input_top_inst (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.pads      (pads),
		.mouse     (mouse),
		.stick_y   (stick_y),
		.cfg       (cfg),
		.port_ctrl (port_ctrl),
		.joy_in    (joy_in)
	);

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	//////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////

	function automatic logic [6:0] ref_pachinko(input stick_axis_t s);
		int pos;
		if (s > `PCE_PACHINKO_HI_LIMIT || s < 128)
			pos = `PCE_PACHINKO_MIN;
		else if (s < `PCE_PACHINKO_LO_LIMIT)
			pos = `PCE_PACHINKO_MAX;
		else
			pos = (128 - (s % 128)) % 128;
		return pos[6:0];
	endfunction

	function automatic port_nibble_t ref_joy_in(
		input port_ctrl_t                  c,
		input port_index_t                 idx,
		input logic                        bank,
		input mouse_phase_t                ph,
		input mouse_byte_t                 sx,
		input mouse_byte_t                 sy,
		input logic                        ml,
		input logic                        mr,
		input pad_buttons_t [NUM_PADS-1:0] pv,
		input input_cfg_t                  cf,
		input stick_axis_t                 s
	);
		port_word_t   w;
		pad_buttons_t b;
		logic [3:0]   motion;
		logic [3:0]   low;
		port_nibble_t n;
		if (c.clr) begin
			n = 4'h0;
		end else begin
			if (idx == 0 && cf.mouse_en) begin
				case (ph)
					MOUSE_X_HI: motion = sx[7:4];
					MOUSE_X_LO: motion = sx[3:0];
					MOUSE_Y_HI: motion = sy[7:4];
					default:    motion = sy[3:0];
				endcase
				low = ~{pv[0][7], pv[0][6], ml, mr};
				w = {motion, low, motion, low};
			end else if (idx == 1 && cf.pachinko_en) begin
				w = {9'd0, ref_pachinko(s)};
			end else if (idx >= NUM_PADS) begin
				w = 16'h0FFF;
			end else begin
				b = pv[idx];
				w[3:0]   = ~{b[7], b[6], b[5], b[4]};
				w[7:4]   = ~{b[1], b[2], b[0], b[3]};
				w[11:8]  = ~{b[11], b[10], b[9], b[8]};
				w[15:12] = 4'h0;
			end
			case ({bank, c.sel})
				2'b00:   n = w[3:0];
				2'b01:   n = w[7:4];
				2'b10:   n = w[11:8];
				default: n = w[15:12];
			endcase
		end
		return n;
	endfunction

	//////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////

	task automatic report_failure();
		$display("Done: errors found");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic check_nibble(input port_nibble_t got, input port_nibble_t exp);
		if (got !== exp) begin
			$display("[ERROR] %0d ns: joy_in is %h, expected %h (clr %b sel %b)",
				$time, got, exp, port_ctrl.clr, port_ctrl.sel);
			report_failure();
		end
	endtask

	task automatic check_index(input port_index_t got, input port_index_t exp);
		if (got !== exp) begin
			$display("[ERROR] %0d ns: scan reads port %0d, expected port %0d",
				$time, got, exp);
			report_failure();
		end
	endtask

	initial begin : compare
		port_index_t exp_pos;
		port_index_t got_pos;
		logic [3:0]  raw;
		forever begin
			wait (req_cnt != ack_cnt);
			if (want_index) begin
				// Pads carry their own number plus one so that zero means no pad
				exp_pos = (m_index < NUM_PADS) ? m_index : port_index_t'(NUM_PADS);
				raw = ~joy_in;
				got_pos = (raw == 4'h0) ? port_index_t'(NUM_PADS) : port_index_t'(raw - 4'd1);
				check_index(got_pos, exp_pos);
			end else begin
				check_nibble(joy_in, ref_joy_in(port_ctrl, m_index, m_bank, m_phase,
					m_snap_x, m_snap_y, m_left, m_right, pads, cfg, stick_y));
			end
			ack_cnt = req_cnt;
		end
	end

	initial begin : watchdog
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		$display("Timeout: tests still running after %0d clock cycles", WATCHDOG_CYCLES);
		report_failure();
	end

	//////////////////////////////////////////////////
	// Stimulus helpers
	//////////////////////////////////////////////////

	// One clock step that also runs the mouse idle count
	task automatic tick();
		@(negedge clk_sys);
		if (port_ctrl.clr) begin
			m_idle = 0;
		end else begin
			m_idle++;
			if (m_idle > `PCE_MOUSE_IDLE_CYCLES)
				m_phase = MOUSE_Y_LO;
		end
	endtask

	task automatic drive_ctrl(input logic clr, input logic sel);
		port_ctrl_t nxt;
		nxt.clr = clr;
		nxt.sel = sel;
		if (nxt.clr) begin
			m_index = '0;
			if (!port_ctrl.clr) begin
				m_bank = cfg.six_button_en ? ~m_bank : 1'b0;
				if (m_phase == MOUSE_Y_LO) begin
					m_snap_x = m_cap_x;
					m_snap_y = m_cap_y;
					m_cap_x = '0;
					m_cap_y = '0;
				end
				m_phase = mouse_phase_t'(m_phase + 2'd1);
			end
		end else if (nxt.sel && !port_ctrl.sel && (cfg.tap_en || cfg.pachinko_en)) begin
			m_index = m_index + 3'd1;
		end
		port_ctrl = nxt;
	endtask

	task automatic request_check(input logic index_check);
		want_index = index_check;
		req_cnt++;
		wait (ack_cnt == req_cnt);
	endtask

	task automatic read_port(input logic clr, input logic sel);
		drive_ctrl(clr, sel);
		repeat (SETTLE) tick();
		request_check(1'b0);
	endtask

	task automatic pulse_clear();
		read_port(1'b1, 1'b0);
		read_port(1'b0, 1'b0);
	endtask

	task automatic randomize_pads();
		for (int k = 0; k < NUM_PADS; k++)
			pads[k] = pad_buttons_t'($urandom);
	endtask

	task automatic send_report(input mouse_byte_t dx, input mouse_byte_t dy,
		input logic l, input logic r);
		mouse.valid = 1'b1;
		mouse.dx = dx;
		mouse.dy = dy;
		mouse.left = l;
		mouse.right = r;
		tick();
		mouse.valid = 1'b0;
		m_cap_x = mouse_byte_t'(-int'(dx));
		m_cap_y = dy;
		m_left = l;
		m_right = r;
		repeat (SETTLE) tick();
	endtask

	task automatic random_report();
		send_report(mouse_byte_t'($urandom), mouse_byte_t'($urandom), 1'($urandom),
			1'($urandom));
	endtask

	task automatic pachinko_read(input stick_axis_t v);
		stick_y = v;
		pulse_clear();
		read_port(1'b0, 1'b1);
		read_port(1'b0, 1'b0);
	endtask

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////

	initial begin : stimulus
		void'($urandom(32'ha4));
		reset = 1'b1;
		pads = '0;
		mouse = '0;
		stick_y = '0;
		cfg = '0;
		port_ctrl = '0;
		m_index = '0;
		m_bank = 1'b0;
		m_phase = MOUSE_Y_LO;
		m_cap_x = '0;
		m_cap_y = '0;
		m_left = 1'b0;
		m_right = 1'b0;
		m_snap_x = '0;
		m_snap_y = '0;
		m_idle = 0;
		want_index = 1'b0;
		repeat (10) @(negedge clk_sys);
		check_nibble(joy_in, 4'h0);
		reset = 1'b0;

		// Two-button pad and clear forcing zero
		for (int r = 0; r < PAD_ROUNDS; r++) begin
			randomize_pads();
			read_port(1'b1, 1'b1);
			read_port(1'b1, 1'b0);
			read_port(1'b0, 1'b0);
			read_port(1'b0, 1'b1);
			read_port(1'b0, 1'b0);
		end

		// Multitap scan with each pad tagged in its button nibble
		cfg.tap_en = 1'b1;
		for (int r = 0; r < TAP_ROUNDS; r++) begin
			randomize_pads();
			for (int k = 0; k < NUM_PADS; k++)
				pads[k][7:4] = 4'(k + 1);
			pulse_clear();
			request_check(1'b1);
			for (int p = 0; p < SCAN_PULSES; p++) begin
				read_port(1'b0, 1'b1);
				read_port(1'b0, 1'b0);
				request_check(1'b1);
			end
		end
		cfg.tap_en = 1'b0;
		pulse_clear();
		for (int p = 0; p < 3; p++) begin
			read_port(1'b0, 1'b1);
			read_port(1'b0, 1'b0);
			request_check(1'b1);
		end

		// Six-button bank on and then off
		cfg.six_button_en = 1'b1;
		for (int r = 0; r < 2 * SIX_ROUNDS; r++) begin
			if (r == SIX_ROUNDS)
				cfg.six_button_en = 1'b0;
			randomize_pads();
			pulse_clear();
			read_port(1'b0, 1'b1);
			read_port(1'b0, 1'b0);
		end

		// Mouse motion sequence
		cfg = '0;
		cfg.mouse_en = 1'b1;
		for (int r = 0; r < MOUSE_ROUNDS; r++) begin
			randomize_pads();
			random_report();
			for (int p = 0; p < MOUSE_PULSES; p++) begin
				pulse_clear();
				read_port(1'b0, 1'b1);
				read_port(1'b0, 1'b0);
			end
		end

		// Idle timeout brings the phase back to the last nibble
		random_report();
		while (m_phase != MOUSE_X_HI)
			pulse_clear();
		random_report();
		repeat (`PCE_MOUSE_IDLE_CYCLES + 16) tick();
		read_port(1'b0, 1'b1);
		read_port(1'b0, 1'b0);
		pulse_clear();
		read_port(1'b0, 1'b1);
		read_port(1'b0, 1'b0);

		// Pachinko on port 1
		cfg = '0;
		cfg.pachinko_en = 1'b1;
		for (int e = 0; e < NUM_EDGES; e++)
			pachinko_read(STICK_EDGES[e]);
		for (int e = 0; e < PACH_RANDOM; e++)
			pachinko_read(stick_axis_t'($urandom));

		$display("Done: no errors");
		$finish;
	end

endmodule

// File: sources.f
+incdir+hw
hw/pce_input_pkg.sv
hw/port_scanner.sv
hw/mouse_tracker.sv
hw/port_word_select.sv
hw/pce_input_top.sv
tb/tb_pce_input.sv

// File: Makefile
# Verilator flow for the controller port front end

TOP := tb_pce_input

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
		--top-module $(TOP) -f sources.f -o $(TOP)

# Pass only when the testbench prints its pass line
run: build
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -q "Done: no errors"

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -Wall \
		--top-module $(TOP) -f sources.f

clean:
	rm -rf obj_dir
